// File: files.f
+incdir+hw
hw/rvCorePkg.sv
hw/decoder.sv
hw/immGen.sv
hw/regFile.sv
hw/alu.sv
hw/dataMem.sv
hw/nextPc.sv
hw/rvCore.sv
tb/tbClock.sv
tb/rvCoreTb.sv

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
	input  rvCorePkg::word_t  a,
	input  rvCorePkg::word_t  b,
	input  rvCorePkg::aluOp_t op,
	output rvCorePkg::word_t  result,
	output logic              zero
);
	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			rvCorePkg::aluAdd:   result = a + b;
			rvCorePkg::aluSub:   result = a - b;
			rvCorePkg::aluSll:   result = a << shamt;
			rvCorePkg::aluSlt:   result = {31'b0, $signed(a) < $signed(b)};
			rvCorePkg::aluSltu:  result = {31'b0, a < b};
			rvCorePkg::aluXor:   result = a ^ b;
			rvCorePkg::aluSrl:   result = a >> shamt;
			rvCorePkg::aluSra:   result = $unsigned($signed(a) >>> shamt);
			rvCorePkg::aluOr:    result = a | b;
			rvCorePkg::aluAnd:   result = a & b;
			rvCorePkg::aluPassB: result = b;   // lui
			default:             result = '0;
		endcase
	end

	assign zero = (result == '0);   // beq / bne after sub

endmodule

// File: hw/dataMem.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module dataMem (
	input  logic                clk,
	input  rvCorePkg::word_t    addr,
	input  rvCorePkg::word_t    wdata,
	input  logic                read,
	input  logic                write,
	input  rvCorePkg::memSize_t size,
	input  logic                unsignedLoad,
	output rvCorePkg::word_t    rdata
);
	localparam int IdxW = $clog2(`DMEM_WORDS);

	rvCorePkg::word_t mem [`DMEM_WORDS];
	logic [IdxW-1:0]  wordIdx;
	logic [1:0]       byteOff;
	logic [3:0]       mask;
	rvCorePkg::word_t laneData;
	rvCorePkg::word_t shifted;
	rvCorePkg::word_t extended;

	assign wordIdx = addr[IdxW+1:2];   // wraps modulo depth
	assign byteOff = addr[1:0];

	always_comb begin
		case (size)
			rvCorePkg::sizeByte: mask = 4'b0001 << byteOff;
			rvCorePkg::sizeHalf: mask = 4'b0011 << byteOff;
			default:             mask = 4'b1111;
		endcase
	end

	assign laneData = wdata << {byteOff, 3'b000};

	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (write && mask[i])
				mem[wordIdx][8*i +: 8] <= laneData[8*i +: 8];
		end
	end

	// move the addressed byte or half down to bit 0
	assign shifted = mem[wordIdx] >> {byteOff, 3'b000};

	always_comb begin
		case (size)
			rvCorePkg::sizeByte:
				extended = {{24{!unsignedLoad && shifted[7]}}, shifted[7:0]};
			rvCorePkg::sizeHalf:
				extended = {{16{!unsignedLoad && shifted[15]}}, shifted[15:0]};
			default:
				extended = shifted;
		endcase
	end

	assign rdata = read ? extended : '0;

	assert property (@(posedge clk) (read || write) && size == rvCorePkg::sizeHalf
		|-> addr[0] == 1'b0)
		else $error("dataMem: odd half access at %h", addr);

	assert property (@(posedge clk) (read || write) && size == rvCorePkg::sizeWord
		|-> addr[1:0] == 2'b00)
		else $error("dataMem: unaligned word access at %h", addr);

endmodule

// File: hw/decoder.sv
`timescale 1ns/1ps

module decoder (
	input  rvCorePkg::instr_t   inst,
	output rvCorePkg::aluOp_t   aluOp,
	output logic                aluSrcImm,
	output rvCorePkg::wbSrc_t   wbSrc,
	output logic                regWrite,
	output logic                memRead,
	output logic                memWrite,
	output rvCorePkg::memSize_t memSize,
	output logic                memUnsigned,
	output rvCorePkg::brKind_t  brKind,
	output logic                ebreak,
	output logic                invalid
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       legal;
	logic       regWriteRaw;
	logic       memReadRaw;
	logic       memWriteRaw;

	// funct3 picks the op; alt selects sub / sra
	function automatic rvCorePkg::aluOp_t aluFromFunct3(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? rvCorePkg::aluSub : rvCorePkg::aluAdd;
			3'b001:  return rvCorePkg::aluSll;
			3'b010:  return rvCorePkg::aluSlt;
			3'b011:  return rvCorePkg::aluSltu;
			3'b100:  return rvCorePkg::aluXor;
			3'b101:  return alt ? rvCorePkg::aluSra : rvCorePkg::aluSrl;
			3'b110:  return rvCorePkg::aluOr;
			default: return rvCorePkg::aluAnd;
		endcase
	endfunction

	assign opcode = inst.r.opcode;
	assign funct3 = inst.r.funct3;
	assign funct7 = inst.r.funct7;

	always_comb begin
		legal       = 1'b0;
		aluOp       = rvCorePkg::aluAdd;
		aluSrcImm   = 1'b0;
		wbSrc       = rvCorePkg::wbAlu;
		regWriteRaw = 1'b0;
		memReadRaw  = 1'b0;
		memWriteRaw = 1'b0;
		memSize     = rvCorePkg::sizeWord;
		memUnsigned = funct3[2];
		brKind      = rvCorePkg::brNone;
		ebreak      = 1'b0;
		case (opcode)
			rvCorePkg::opLui: begin
				legal       = 1'b1;
				aluOp       = rvCorePkg::aluPassB;   // imm straight through
				aluSrcImm   = 1'b1;
				regWriteRaw = 1'b1;
			end
			rvCorePkg::opAuipc: begin
				legal       = 1'b1;
				wbSrc       = rvCorePkg::wbPcPlusImm;
				regWriteRaw = 1'b1;
			end
			rvCorePkg::opJal: begin
				legal       = 1'b1;
				wbSrc       = rvCorePkg::wbPcPlus4;
				regWriteRaw = 1'b1;
				brKind      = rvCorePkg::brJal;
			end
			rvCorePkg::opJalr: begin
				legal       = (funct3 == 3'b000);
				aluSrcImm   = 1'b1;   // target = rs1 + imm
				wbSrc       = rvCorePkg::wbPcPlus4;
				regWriteRaw = 1'b1;
				brKind      = rvCorePkg::brJalr;
			end
			rvCorePkg::opBranch: begin
				legal = (funct3 != 3'b010) && (funct3 != 3'b011);
				case (funct3)
					3'b000: begin
						aluOp  = rvCorePkg::aluSub;
						brKind = rvCorePkg::brEq;
					end
					3'b001: begin
						aluOp  = rvCorePkg::aluSub;
						brKind = rvCorePkg::brNe;
					end
					3'b100: begin
						aluOp  = rvCorePkg::aluSlt;
						brKind = rvCorePkg::brLt;
					end
					3'b101: begin
						aluOp  = rvCorePkg::aluSlt;
						brKind = rvCorePkg::brGe;
					end
					3'b110: begin
						aluOp  = rvCorePkg::aluSltu;
						brKind = rvCorePkg::brLtu;
					end
					default: begin
						aluOp  = rvCorePkg::aluSltu;
						brKind = rvCorePkg::brGeu;
					end
				endcase
			end
			rvCorePkg::opLoad: begin
				legal       = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);
				aluSrcImm   = 1'b1;
				wbSrc       = rvCorePkg::wbMem;
				regWriteRaw = 1'b1;
				memReadRaw  = 1'b1;
			end
			rvCorePkg::opStore: begin
				legal       = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
				aluSrcImm   = 1'b1;
				memWriteRaw = 1'b1;
			end
			rvCorePkg::opImm: begin
				if (funct3 == 3'b001)
					legal = (funct7 == 7'b0000000);
				else if (funct3 == 3'b101)
					legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
				else
					legal = 1'b1;
				// funct7 only matters for srai, addi has no subtract form
				aluOp       = aluFromFunct3(funct3, funct3 == 3'b101 && funct7[5]);
				aluSrcImm   = 1'b1;
				regWriteRaw = 1'b1;
			end
			rvCorePkg::opReg: begin
				legal = (funct7 == 7'b0000000) ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
				aluOp       = aluFromFunct3(funct3, funct7[5]);
				regWriteRaw = 1'b1;
			end
			rvCorePkg::opSystem: begin
				legal  = (inst == 32'h00100073);   // ebreak only
				ebreak = legal;
			end
			default: legal = 1'b0;
		endcase
		// size from funct3[1:0], sign from funct3[2]
		case (funct3[1:0])
			2'b00:   memSize = rvCorePkg::sizeByte;
			2'b01:   memSize = rvCorePkg::sizeHalf;
			default: memSize = rvCorePkg::sizeWord;
		endcase
	end

	assign invalid  = !legal;
	assign regWrite = regWriteRaw && legal;
	assign memRead  = memReadRaw && legal;
	assign memWrite = memWriteRaw && legal;

	always_comb begin
		assert (!(memRead && memWrite))
			else $error("decoder: load and store decoded together for %h", inst);
	end

endmodule

// File: hw/immGen.sv
`timescale 1ns/1ps

module immGen (
	input  rvCorePkg::instr_t inst,
	output rvCorePkg::word_t  imm
);

	always_comb begin
		case (inst.r.opcode)
			rvCorePkg::opImm, rvCorePkg::opLoad, rvCorePkg::opJalr:
				imm = {{20{inst.i.imm[11]}}, inst.i.imm};
			rvCorePkg::opStore:
				imm = {{20{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
			rvCorePkg::opBranch:   // bit 0 always zero
				imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
					inst.b.immHi, inst.b.immLo, 1'b0};
			rvCorePkg::opLui, rvCorePkg::opAuipc:
				imm = {inst.u.imm, 12'b0};
			rvCorePkg::opJal:
				imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.immHi,
					inst.j.imm11, inst.j.immLo, 1'b0};
			default:
				imm = '0;   // R-type and system carry none
		endcase
	end

endmodule

// File: hw/nextPc.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module nextPc (
	input  logic               clk,
	input  logic               rst,
	input  rvCorePkg::brKind_t brKind,
	input  rvCorePkg::word_t   imm,
	input  rvCorePkg::word_t   aluResult,
	input  logic               zero,
	input  logic               hold,
	input  logic               ebreak,
	output rvCorePkg::word_t   pc,
	output rvCorePkg::word_t   pcPlus4,
	output rvCorePkg::word_t   pcPlusImm,
	output logic               halted
);
	logic             taken;
	rvCorePkg::word_t pcNext;

	assign pcPlus4   = pc + `XLEN'd4;
	assign pcPlusImm = pc + imm;

	// bit 0 of aluResult is the slt / sltu answer
	always_comb begin
		case (brKind)
			rvCorePkg::brEq:  taken = zero;
			rvCorePkg::brNe:  taken = !zero;
			rvCorePkg::brLt:  taken = aluResult[0];
			rvCorePkg::brGe:  taken = !aluResult[0];
			rvCorePkg::brLtu: taken = aluResult[0];
			rvCorePkg::brGeu: taken = !aluResult[0];
			rvCorePkg::brJal: taken = 1'b1;
			default:          taken = 1'b0;
		endcase
	end

	always_comb begin
		if (brKind == rvCorePkg::brJalr)
			pcNext = {aluResult[`XLEN-1:1], 1'b0};
		else if (taken)
			pcNext = pcPlusImm;
		else
			pcNext = pcPlus4;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc     <= `RESET_PC;
			halted <= 1'b0;
		end else if (!hold) begin
			if (ebreak)
				halted <= 1'b1;   // pc parks on the ebreak
			else
				pc <= pcNext;
		end
	end

	assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else $error("nextPc: pc %h not word aligned", pc);

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic                clk,
	input  logic                rst,
	input  rvCorePkg::regIdx_t  rs1,
	input  rvCorePkg::regIdx_t  rs2,
	input  rvCorePkg::regIdx_t  rd,
	input  logic                we,
	input  rvCorePkg::word_t    wdata,
	output rvCorePkg::word_t    rs1Data,
	output rvCorePkg::word_t    rs2Data
);
	rvCorePkg::word_t regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	// x0 reads as zero whatever the array holds
	assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: hw/rvCore.sv
`timescale 1ns/1ps

module rvCore (
	input  logic               clk,
	input  logic               rst,
	input  rvCorePkg::word_t   inst,
	output rvCorePkg::word_t   pc,
	output logic               invalid,
	output logic               halted,
	output logic               wbEn,
	output rvCorePkg::regIdx_t wbAddr,
	output rvCorePkg::word_t   wbData
);
	rvCorePkg::instr_t   instU;

	rvCorePkg::aluOp_t   aluOp;
	logic                aluSrcImm;
	rvCorePkg::wbSrc_t   wbSrc;
	logic                regWrite;
	logic                memRead;
	logic                memWrite;
	rvCorePkg::memSize_t memSize;
	logic                memUnsigned;
	rvCorePkg::brKind_t  brKind;
	logic                ebreak;

	rvCorePkg::word_t    imm;
	rvCorePkg::word_t    rs1Data;
	rvCorePkg::word_t    rs2Data;
	rvCorePkg::word_t    aluB;
	rvCorePkg::word_t    aluResult;
	logic                zero;
	rvCorePkg::word_t    loadData;
	rvCorePkg::word_t    pcPlus4;
	rvCorePkg::word_t    pcPlusImm;
	logic                regWe;
	logic                storeEn;
	logic                hold;

	assign instU = inst;

	decoder u_decoder (
		.inst        (instU),
		.aluOp       (aluOp),
		.aluSrcImm   (aluSrcImm),
		.wbSrc       (wbSrc),
		.regWrite    (regWrite),
		.memRead     (memRead),
		.memWrite    (memWrite),
		.memSize     (memSize),
		.memUnsigned (memUnsigned),
		.brKind      (brKind),
		.ebreak      (ebreak),
		.invalid     (invalid)
	);

	immGen u_immGen (
		.inst (instU),
		.imm  (imm)
	);

	// nothing commits for a bad word or once halted
	assign hold    = invalid || halted;
	assign regWe   = regWrite && !hold;
	assign storeEn = memWrite && !hold;

	regFile u_regFile (
		.clk     (clk),
		.rst     (rst),
		.rs1     (instU.r.rs1),
		.rs2     (instU.r.rs2),
		.rd      (instU.r.rd),
		.we      (regWe),
		.wdata   (wbData),
		.rs1Data (rs1Data),
		.rs2Data (rs2Data)
	);

	assign aluB = aluSrcImm ? imm : rs2Data;

	alu u_alu (
		.a      (rs1Data),
		.b      (aluB),
		.op     (aluOp),
		.result (aluResult),
		.zero   (zero)
	);

	dataMem u_dataMem (
		.clk          (clk),
		.addr         (aluResult),
		.wdata        (rs2Data),
		.read         (memRead),
		.write        (storeEn),
		.size         (memSize),
		.unsignedLoad (memUnsigned),
		.rdata        (loadData)
	);

	nextPc u_nextPc (
		.clk       (clk),
		.rst       (rst),
		.brKind    (brKind),
		.imm       (imm),
		.aluResult (aluResult),
		.zero      (zero),
		.hold      (hold),
		.ebreak    (ebreak),
		.pc        (pc),
		.pcPlus4   (pcPlus4),
		.pcPlusImm (pcPlusImm),
		.halted    (halted)
	);

	always_comb begin
		case (wbSrc)
			rvCorePkg::wbMem:       wbData = loadData;
			rvCorePkg::wbPcPlus4:   wbData = pcPlus4;     // jal / jalr link
			rvCorePkg::wbPcPlusImm: wbData = pcPlusImm;   // auipc
			default:                wbData = aluResult;
		endcase
	end

	// trace of the retiring write
	assign wbEn   = regWe && (instU.r.rd != 5'd0);
	assign wbAddr = instU.r.rd;

endmodule

// File: hw/rvCorePkg.sv
`include "rvCore_macros.svh"

package rvCorePkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [4:0] regIdx_t;

	// major opcodes of the supported subset
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opReg    = 7'b0110011;
	localparam logic [6:0] opSystem = 7'b1110011;

	typedef struct packed {
		logic [6:0] funct7;
		regIdx_t    rs2;
		regIdx_t    rs1;
		logic [2:0] funct3;
		regIdx_t    rd;
		logic [6:0] opcode;
	} rFmt_t;

	typedef struct packed {
		logic [11:0] imm;
		regIdx_t     rs1;
		logic [2:0]  funct3;
		regIdx_t     rd;
		logic [6:0]  opcode;
	} iFmt_t;

	typedef struct packed {
		logic [6:0] immHi;   // imm[11:5]
		regIdx_t    rs2;
		regIdx_t    rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;   // imm[4:0]
		logic [6:0] opcode;
	} sFmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] immHi;   // imm[10:5]
		regIdx_t    rs2;
		regIdx_t    rs1;
		logic [2:0] funct3;
		logic [3:0] immLo;   // imm[4:1]
		logic       imm11;
		logic [6:0] opcode;
	} bFmt_t;

	typedef struct packed {
		logic [19:0] imm;    // imm[31:12]
		regIdx_t     rd;
		logic [6:0]  opcode;
	} uFmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] immLo;   // imm[10:1]
		logic       imm11;
		logic [7:0] immHi;   // imm[19:12]
		regIdx_t    rd;
		logic [6:0] opcode;
	} jFmt_t;

	// one fetched word, seen through every format
	typedef union packed {
		rFmt_t r;
		iFmt_t i;
		sFmt_t s;
		bFmt_t b;
		uFmt_t u;
		jFmt_t j;
	} instr_t;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
		aluSrl, aluSra, aluOr, aluAnd, aluPassB
	} aluOp_t;

	typedef enum logic [1:0] {wbAlu, wbMem, wbPcPlus4, wbPcPlusImm} wbSrc_t;

	typedef enum logic [1:0] {sizeByte, sizeHalf, sizeWord} memSize_t;

	// nine kinds, so four bits
	typedef enum logic [3:0] {
		brNone, brEq, brNe, brLt, brGe, brLtu, brGeu, brJal, brJalr
	} brKind_t;

endpackage

// File: hw/rvCore_macros.svh
`ifndef RVCORE_MACROS_SVH
`define RVCORE_MACROS_SVH

// data and address width
`define XLEN 32

// first fetch address, also the base of the data memory
`define RESET_PC 32'h80000000

// data memory depth in 32-bit words
`define DMEM_WORDS 256

`endif

// File: run.sh
#!/usr/bin/env bash
# build and run the rvCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module rvCoreTb -o rvCoreSim

output=$(./obj_dir/rvCoreSim)
echo "$output"

if echo "$output" | grep -q "TEST PASSED"; then
	exit 0
else
	exit 1
fi

// File: tb/rvCoreTb.sv
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module rvCoreTb;

	localparam logic [6:0] opcLui    = 7'b0110111;
	localparam logic [6:0] opcAuipc  = 7'b0010111;
	localparam logic [6:0] opcJal    = 7'b1101111;
	localparam logic [6:0] opcJalr   = 7'b1100111;
	localparam logic [6:0] opcBranch = 7'b1100011;
	localparam logic [6:0] opcLoad   = 7'b0000011;
	localparam logic [6:0] opcStore  = 7'b0100011;
	localparam logic [6:0] opcImm    = 7'b0010011;
	localparam logic [6:0] opcReg    = 7'b0110011;

	localparam rvCorePkg::word_t nopInstr    = 32'h00000013;   // addi x0, x0, 0
	localparam rvCorePkg::word_t ebreakInstr = 32'h00100073;
	localparam int randomCount = 40;
	localparam int waitLimit   = 16;     // cycles for any single wait
	localparam int runLimit    = 2000;   // whole run

	typedef struct packed {
		rvCorePkg::word_t   instr;
		rvCorePkg::word_t   pc;       // pc before issue
		logic               wbEn;
		rvCorePkg::regIdx_t wbAddr;
		rvCorePkg::word_t   wbData;
		logic               invalid;
	} step_t;

	logic               clk;
	logic               rst;
	rvCorePkg::word_t   inst;
	rvCorePkg::word_t   pc;
	logic               invalid;
	logic               halted;
	logic               wbEn;
	rvCorePkg::regIdx_t wbAddr;
	rvCorePkg::word_t   wbData;

	step_t            steps [$];
	rvCorePkg::word_t model [32];   // expected register contents
	rvCorePkg::word_t pcTrack;
	logic [31:0]      rngState;
	int               valueErrors;
	int               otherErrors;

	tbClock #(.PeriodNs(4)) u_tbClock (.clk(clk));

	rvCore u_rvCore (
		.clk     (clk),
		.rst     (rst),
		.inst    (inst),
		.pc      (pc),
		.invalid (invalid),
		.halted  (halted),
		.wbEn    (wbEn),
		.wbAddr  (wbAddr),
		.wbData  (wbData)
	);

	function automatic rvCorePkg::word_t iType(input logic [6:0] op, input logic [4:0] rd,
		input logic [2:0] f3, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rvCorePkg::word_t rType(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opcReg};
	endfunction

	function automatic rvCorePkg::word_t sType(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opcStore};
	endfunction

	// imm is the byte offset, bit 0 dropped
	function automatic rvCorePkg::word_t bType(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [31:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opcBranch};
	endfunction

	function automatic rvCorePkg::word_t uType(input logic [6:0] op, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic rvCorePkg::word_t jType(input logic [4:0] rd, input logic [31:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opcJal};
	endfunction

	function automatic rvCorePkg::word_t sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic checkWord(input string name, input rvCorePkg::word_t exp,
		input rvCorePkg::word_t act);
		if (act !== exp) begin
			valueErrors++;
			$display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic checkReg(input string name, input rvCorePkg::regIdx_t exp,
		input rvCorePkg::regIdx_t act);
		if (act !== exp) begin
			valueErrors++;
			$display("** Error at %0t: %s expected x%0d, got x%0d", $time, name, exp, act);
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			valueErrors++;
			$display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic addStep(input rvCorePkg::word_t instr, input logic en,
		input rvCorePkg::regIdx_t rd, input rvCorePkg::word_t data);
		steps.push_back('{instr, pcTrack, en, rd, data, 1'b0});
		pcTrack = pcTrack + 32'd4;
	endtask

	task automatic addJump(input rvCorePkg::word_t instr, input logic en,
		input rvCorePkg::regIdx_t rd, input rvCorePkg::word_t data,
		input rvCorePkg::word_t target);
		steps.push_back('{instr, pcTrack, en, rd, data, 1'b0});
		pcTrack = target;
	endtask

	task automatic addInvalid(input rvCorePkg::word_t instr);
		steps.push_back('{instr, pcTrack, 1'b0, 5'd0, 32'h0, 1'b1});   // pc must hold
	endtask

	task automatic buildTable();
		// upper immediates and addi
		addStep(iType(opcImm, 5'd1, 3'b000, 5'd0, 12'd5), 1'b1, 5'd1, 32'h00000005);
		addStep(iType(opcImm, 5'd2, 3'b000, 5'd0, 12'hffd), 1'b1, 5'd2, 32'hfffffffd);
		addStep(uType(opcLui, 5'd3, 20'h12345), 1'b1, 5'd3, 32'h12345000);
		addStep(uType(opcAuipc, 5'd4, 20'h00001), 1'b1, 5'd4, pcTrack + 32'h1000);
		addStep(iType(opcImm, 5'd3, 3'b000, 5'd3, 12'h678), 1'b1, 5'd3, 32'h12345678);
		// register-register ops, x1 = 5 and x2 = -3
		addStep(rType(7'h20, 5'd2, 5'd1, 3'b000, 5'd6), 1'b1, 5'd6, 32'h00000008);
		addStep(rType(7'h00, 5'd1, 5'd1, 3'b001, 5'd7), 1'b1, 5'd7, 32'h000000a0);
		addStep(rType(7'h00, 5'd1, 5'd2, 3'b101, 5'd8), 1'b1, 5'd8, 32'h07ffffff);
		addStep(rType(7'h20, 5'd1, 5'd2, 3'b101, 5'd9), 1'b1, 5'd9, 32'hffffffff);
		addStep(rType(7'h00, 5'd1, 5'd2, 3'b010, 5'd10), 1'b1, 5'd10, 32'h00000001);
		addStep(rType(7'h00, 5'd1, 5'd2, 3'b011, 5'd11), 1'b1, 5'd11, 32'h00000000);
		addStep(rType(7'h00, 5'd2, 5'd1, 3'b100, 5'd12), 1'b1, 5'd12, 32'hfffffff8);
		addStep(rType(7'h00, 5'd3, 5'd1, 3'b110, 5'd13), 1'b1, 5'd13, 32'h1234567d);
		addStep(rType(7'h00, 5'd2, 5'd3, 3'b111, 5'd14), 1'b1, 5'd14, 32'h12345678);
		addStep(rType(7'h00, 5'd1, 5'd1, 3'b000, 5'd0), 1'b0, 5'd0, 32'h0);   // x0 target
		// stores then loads around 0x80000100
		addStep(uType(opcLui, 5'd5, 20'h80000), 1'b1, 5'd5, 32'h80000000);
		addStep(iType(opcImm, 5'd5, 3'b000, 5'd5, 12'h100), 1'b1, 5'd5, 32'h80000100);
		addStep(sType(3'b010, 5'd5, 5'd3, 12'd0), 1'b0, 5'd0, 32'h0);
		addStep(sType(3'b001, 5'd5, 5'd2, 12'd4), 1'b0, 5'd0, 32'h0);
		addStep(sType(3'b000, 5'd5, 5'd12, 12'd6), 1'b0, 5'd0, 32'h0);
		addStep(sType(3'b000, 5'd5, 5'd1, 12'd7), 1'b0, 5'd0, 32'h0);
		addStep(iType(opcLoad, 5'd15, 3'b010, 5'd5, 12'd0), 1'b1, 5'd15, 32'h12345678);
		addStep(iType(opcLoad, 5'd16, 3'b001, 5'd5, 12'd4), 1'b1, 5'd16, 32'hfffffffd);
		addStep(iType(opcLoad, 5'd17, 3'b101, 5'd5, 12'd4), 1'b1, 5'd17, 32'h0000fffd);
		addStep(iType(opcLoad, 5'd18, 3'b000, 5'd5, 12'd6), 1'b1, 5'd18, 32'hfffffff8);
		addStep(iType(opcLoad, 5'd19, 3'b100, 5'd5, 12'd6), 1'b1, 5'd19, 32'h000000f8);
		addStep(iType(opcLoad, 5'd20, 3'b000, 5'd5, 12'd1), 1'b1, 5'd20, 32'h00000056);
		addStep(iType(opcLoad, 5'd21, 3'b101, 5'd5, 12'd2), 1'b1, 5'd21, 32'h00001234);
		addStep(iType(opcLoad, 5'd22, 3'b010, 5'd5, 12'd4), 1'b1, 5'd22, 32'h05f8fffd);
		// branches, taken then untaken
		addJump(bType(3'b000, 5'd1, 5'd1, 32'd8), 1'b0, 5'd0, 32'h0, pcTrack + 32'd8);
		addJump(bType(3'b000, 5'd1, 5'd2, 32'd8), 1'b0, 5'd0, 32'h0, pcTrack + 32'd4);
		addJump(bType(3'b001, 5'd1, 5'd2, 32'd12), 1'b0, 5'd0, 32'h0, pcTrack + 32'd12);
		addJump(bType(3'b001, 5'd1, 5'd1, 32'd12), 1'b0, 5'd0, 32'h0, pcTrack + 32'd4);
		addJump(bType(3'b100, 5'd2, 5'd1, 32'hfffffff0), 1'b0, 5'd0, 32'h0,
			pcTrack - 32'd16);   // backwards by 16
		addJump(bType(3'b100, 5'd1, 5'd2, 32'd16), 1'b0, 5'd0, 32'h0, pcTrack + 32'd4);
		addJump(bType(3'b111, 5'd2, 5'd1, 32'd20), 1'b0, 5'd0, 32'h0, pcTrack + 32'd20);
		addJump(bType(3'b111, 5'd1, 5'd2, 32'd8), 1'b0, 5'd0, 32'h0, pcTrack + 32'd4);
		addJump(jType(5'd23, 32'd16), 1'b1, 5'd23, pcTrack + 32'd4, pcTrack + 32'd16);
		addJump(iType(opcJalr, 5'd24, 3'b000, 5'd5, 12'h031), 1'b1, 5'd24, pcTrack + 32'd4,
			(32'h80000100 + 32'h31) & ~32'h1);
		// load with funct3 011, then a write at the same pc
		addInvalid(iType(opcLoad, 5'd25, 3'b011, 5'd0, 12'd0));
		addStep(iType(opcImm, 5'd25, 3'b000, 5'd0, 12'd1), 1'b1, 5'd25, 32'h00000001);
	endtask

	task automatic applyStep(input step_t e);
		@(posedge clk);
		inst <= e.instr;
		@(negedge clk);   // outputs settled well before the next edge
		checkWord("pc", e.pc, pc);
		checkFlag("invalid", e.invalid, invalid);
		checkFlag("wbEn", e.wbEn, wbEn);
		if (e.wbEn) begin
			checkReg("wbAddr", e.wbAddr, wbAddr);
			checkWord("wbData", e.wbData, wbData);
			model[e.wbAddr] = e.wbData;
		end
	endtask

	task automatic waitResetRelease();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (rst !== 1'b0 && cycles < waitLimit) begin
			@(negedge clk);
			cycles++;
		end
		if (rst !== 1'b0) begin
			otherErrors++;
			$display("reset was still high after %0d cycles", waitLimit);
		end
		checkWord("pc", `RESET_PC, pc);
		checkFlag("halted", 1'b0, halted);
		checkFlag("wbEn", 1'b0, wbEn);   // reset nop writes x0
	endtask

	task automatic runRandom();
		logic [31:0]        r;
		int                 kind;
		rvCorePkg::regIdx_t rd;
		rvCorePkg::regIdx_t rs1;
		rvCorePkg::regIdx_t rs2;
		logic [11:0]        imm;
		rvCorePkg::word_t   instr;
		rvCorePkg::word_t   expData;
		for (int i = 0; i < randomCount; i++) begin
			rngState = xorshift(rngState);
			r = rngState;
			kind = int'(r % 32'd3);
			rd = r[6:2];
			rs1 = r[11:7];
			rs2 = r[16:12];
			imm = r[28:17];
			case (kind)
				0: begin
					instr = iType(opcImm, rd, 3'b000, rs1, imm);
					expData = model[rs1] + sext12(imm);
				end
				1: begin
					instr = iType(opcImm, rd, 3'b100, rs1, imm);   // xori
					expData = model[rs1] ^ sext12(imm);
				end
				default: begin
					instr = rType(7'h00, rs2, rs1, 3'b000, rd);
					expData = model[rs1] + model[rs2];
				end
			endcase
			applyStep('{instr, pcTrack, rd != 5'd0, rd, expData, 1'b0});
			pcTrack = pcTrack + 32'd4;
		end
	endtask

	task automatic checkHalt();
		int               cycles;
		rvCorePkg::word_t parkedPc;
		parkedPc = pcTrack;
		applyStep('{ebreakInstr, pcTrack, 1'b0, 5'd0, 32'h0, 1'b0});
		cycles = 0;
		while (halted !== 1'b1 && cycles < waitLimit) begin
			@(posedge clk);
			inst <= iType(opcImm, 5'd1, 3'b000, 5'd0, 12'd1);   // would write if running
			@(negedge clk);
			cycles++;
		end
		if (halted !== 1'b1) begin
			otherErrors++;
			$display("core did not halt within %0d cycles after ebreak", waitLimit);
		end else begin
			for (int i = 0; i < 3; i++) begin
				checkWord("pc", parkedPc, pc);
				checkFlag("wbEn", 1'b0, wbEn);
				@(posedge clk);
				inst <= iType(opcImm, 5'd1, 3'b000, 5'd0, 12'd1);
				@(negedge clk);
			end
			checkFlag("halted", 1'b1, halted);
		end
	endtask

	initial begin
		rst = 1'b1;
		inst = nopInstr;
		valueErrors = 0;
		otherErrors = 0;
		rngState = 32'hc5a5;
		foreach (model[i])
			model[i] = '0;
		pcTrack = `RESET_PC + 32'd4;   // the reset nop retires at RESET_PC
		buildTable();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		waitResetRelease();
		foreach (steps[i])
			applyStep(steps[i]);
		runRandom();
		checkHalt();
		$display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// overall run limit
	initial begin
		repeat (runLimit) @(posedge clk);
		$display("run did not finish within %0d cycles", runLimit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: tb/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int PeriodNs = 4
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PeriodNs / 2) clk = ~clk;   // 50% duty

endmodule
